// ==== source/mb_enc_pkg.sv ====
// Shared types, constants and helpers for the macroblock encoder core
// Sample and level widths, edge defaults, controller states

package mb_enc_pkg;

    typedef logic [7:0]        pix_t;
    typedef logic signed [8:0] level_t;
    typedef logic [3:0]        col_t;
    typedef logic [7:0]        row_t;
    typedef logic [2:0]        qshift_t;
    typedef logic [35:0]       word_t;

    localparam int   MAX_MB_COLS  = 16;
    localparam int   Y_SAMPLES    = 16;
    localparam int   UV_SAMPLES   = 4;
    localparam int   WORDS_PER_MB = 7;
    localparam pix_t TOP_DEFAULT  = 8'd127;
    localparam pix_t LEFT_DEFAULT = 8'd129;

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        FETCH,
        WAIT_PACK,
        ADVANCE,
        DONE
    } ctrl_state_t;

    // Sign-magnitude shift quantizer
    function automatic level_t quant_level(pix_t s, pix_t dc, qshift_t q);
        logic signed [9:0] res;
        logic [7:0]        mag;
        level_t            lv;
        res = $signed({2'b00, s}) - $signed({2'b00, dc});
        mag = res[9] ? 8'(-res) : 8'(res);
        lv  = {1'b0, mag >> q};
        return res[9] ? -lv : lv;
    endfunction

    // Dequantize and clamp to 0..255
    function automatic pix_t recon_pix(pix_t dc, level_t lv, qshift_t q);
        logic [7:0]        step;
        logic signed [9:0] sum;
        step = 8'((lv[8] ? -lv : lv) << q);
        if (lv[8]) begin
            sum = $signed({2'b00, dc}) - $signed({2'b00, step});
        end else begin
            sum = $signed({2'b00, dc}) + $signed({2'b00, step});
        end
        if (sum < 0) begin
            return 8'd0;
        end
        return (sum > 255) ? 8'd255 : sum[7:0];
    endfunction

endpackage

// ==== source/mb_context_store.sv ====
// Macroblock context store
// Line buffer of reconstructed bottom rows per column and the left
// column registers; applies frame edge defaults on its outputs

`timescale 1ns/10ps

module mb_context_store (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  mb_enc_pkg::col_t                              mb_col,
    input  mb_enc_pkg::row_t                              mb_row,
    input  logic                                          ctx_update,
    input  mb_enc_pkg::pix_t [mb_enc_pkg::Y_SAMPLES-1:0]  y_recon,
    input  mb_enc_pkg::pix_t [2*mb_enc_pkg::UV_SAMPLES-1:0] uv_recon,
    output mb_enc_pkg::pix_t [3:0]                        top_y,
    output mb_enc_pkg::pix_t [3:0]                        left_y,
    output mb_enc_pkg::pix_t [3:0]                        top_uv,
    output mb_enc_pkg::pix_t [3:0]                        left_uv
);
    import mb_enc_pkg::*;

    // U in entries 0..1, V in entries 2..3
    pix_t [3:0] top_y_mem  [MAX_MB_COLS];
    pix_t [3:0] top_uv_mem [MAX_MB_COLS];
    pix_t [3:0] left_y_q;
    pix_t [3:0] left_uv_q;

    //------------------------------------------------------------------------
    // Bottom rows into the line buffer
    //------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ctx_update) begin
            top_y_mem[mb_col]  <= y_recon[15:12];
            top_uv_mem[mb_col] <= {uv_recon[7:6], uv_recon[3:2]};
        end
    end

    // Right columns become the next block's left
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_y_q  <= {4{LEFT_DEFAULT}};
            left_uv_q <= {4{LEFT_DEFAULT}};
        end else if (ctx_update) begin
            left_y_q  <= {y_recon[15], y_recon[11], y_recon[7], y_recon[3]};
            left_uv_q <= {uv_recon[7], uv_recon[5], uv_recon[3], uv_recon[1]};
        end
    end

    //------------------------------------------------------------------------
    // Edge defaults
    //------------------------------------------------------------------------
    assign top_y   = (mb_row == '0) ? {4{TOP_DEFAULT}} : top_y_mem[mb_col];
    assign top_uv  = (mb_row == '0) ? {4{TOP_DEFAULT}} : top_uv_mem[mb_col];
    assign left_y  = (mb_col == '0) ? {4{LEFT_DEFAULT}} : left_y_q;
    assign left_uv = (mb_col == '0) ? {4{LEFT_DEFAULT}} : left_uv_q;

endmodule

// ==== source/luma_dc_quant.sv ====
// Luma DC prediction and shift quantization for one 4x4 block
// Stage one captures samples and forms dc, stage two gives levels and recon

`timescale 1ns/10ps

module luma_dc_quant (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           mb_start,
    input  mb_enc_pkg::pix_t [mb_enc_pkg::Y_SAMPLES-1:0]   y_in,
    input  mb_enc_pkg::pix_t [3:0]                         top_y,
    input  mb_enc_pkg::pix_t [3:0]                         left_y,
    input  mb_enc_pkg::qshift_t                            q_shift_y,
    output logic                                           y_valid,
    output mb_enc_pkg::pix_t                               dc_y,
    output mb_enc_pkg::level_t [mb_enc_pkg::Y_SAMPLES-1:0] y_levels,
    output mb_enc_pkg::pix_t [mb_enc_pkg::Y_SAMPLES-1:0]   y_recon
);
    import mb_enc_pkg::*;

    pix_t [Y_SAMPLES-1:0]   samp_q;
    qshift_t                qsh_q;
    logic                   stage1_vld;
    logic [10:0]            dc_sum;
    level_t [Y_SAMPLES-1:0] lvl_c;
    pix_t [Y_SAMPLES-1:0]   rec_c;

    // Rounded mean of four top and four left samples
    always_comb begin
        dc_sum = 11'd4;
        for (int i = 0; i < 4; i++) begin
            dc_sum = dc_sum + top_y[i] + left_y[i];
        end
    end

    //------------------------------------------------------------------------
    // Stage one
    //------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (mb_start) begin
            samp_q <= y_in;
            qsh_q  <= q_shift_y;
            dc_y   <= dc_sum[10:3];
        end
    end

    always_comb begin
        for (int i = 0; i < Y_SAMPLES; i++) begin
            lvl_c[i] = quant_level(samp_q[i], dc_y, qsh_q);
            rec_c[i] = recon_pix(dc_y, lvl_c[i], qsh_q);
        end
    end

    //------------------------------------------------------------------------
    // Stage two
    //------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (stage1_vld) begin
            y_levels <= lvl_c;
            y_recon  <= rec_c;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage1_vld <= 1'b0;
            y_valid    <= 1'b0;
        end else begin
            stage1_vld <= mb_start;
            y_valid    <= stage1_vld;
        end
    end

endmodule

// ==== source/chroma_dc_quant.sv ====
// Chroma DC prediction and shift quantization for the U and V 2x2 planes
// Same two stages as the luma path, both planes side by side

`timescale 1ns/10ps

module chroma_dc_quant (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              mb_start,
    input  mb_enc_pkg::pix_t [2*mb_enc_pkg::UV_SAMPLES-1:0]   uv_in,
    input  mb_enc_pkg::pix_t [3:0]                            top_uv,
    input  mb_enc_pkg::pix_t [3:0]                            left_uv,
    input  mb_enc_pkg::qshift_t                               q_shift_uv,
    output logic                                              uv_valid,
    output mb_enc_pkg::pix_t                                  dc_u,
    output mb_enc_pkg::pix_t                                  dc_v,
    output mb_enc_pkg::level_t [2*mb_enc_pkg::UV_SAMPLES-1:0] uv_levels,
    output mb_enc_pkg::pix_t [2*mb_enc_pkg::UV_SAMPLES-1:0]   uv_recon
);
    import mb_enc_pkg::*;

    pix_t [2*UV_SAMPLES-1:0]   samp_q;
    qshift_t                   qsh_q;
    logic                      stage1_vld;
    logic [9:0]                sum_u;
    logic [9:0]                sum_v;
    level_t [2*UV_SAMPLES-1:0] lvl_c;
    pix_t [2*UV_SAMPLES-1:0]   rec_c;

    // Context entries 0..1 are U, 2..3 are V
    assign sum_u = 10'd2 + top_uv[0] + top_uv[1] + left_uv[0] + left_uv[1];
    assign sum_v = 10'd2 + top_uv[2] + top_uv[3] + left_uv[2] + left_uv[3];

    //------------------------------------------------------------------------
    // Stage one
    //------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (mb_start) begin
            samp_q <= uv_in;
            qsh_q  <= q_shift_uv;
            dc_u   <= sum_u[9:2];
            dc_v   <= sum_v[9:2];
        end
    end

    always_comb begin
        for (int i = 0; i < 2 * UV_SAMPLES; i++) begin
            pix_t dc_sel;
            dc_sel   = (i < UV_SAMPLES) ? dc_u : dc_v;
            lvl_c[i] = quant_level(samp_q[i], dc_sel, qsh_q);
            rec_c[i] = recon_pix(dc_sel, lvl_c[i], qsh_q);
        end
    end

    //------------------------------------------------------------------------
    // Stage two
    //------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (stage1_vld) begin
            uv_levels <= lvl_c;
            uv_recon  <= rec_c;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage1_vld <= 1'b0;
            uv_valid   <= 1'b0;
        end else begin
            stage1_vld <= mb_start;
            uv_valid   <= stage1_vld;
        end
    end

endmodule

// ==== source/mb_level_packer.sv ====
// Level packer
// Latches the header and levels of one macroblock and writes them to the
// output FIFO as seven words, holding while the FIFO is full

`timescale 1ns/10ps

module mb_level_packer (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              y_valid,
    input  logic                                              uv_valid,
    input  mb_enc_pkg::col_t                                  mb_col,
    input  mb_enc_pkg::row_t                                  mb_row,
    input  mb_enc_pkg::pix_t                                  dc_y,
    input  mb_enc_pkg::pix_t                                  dc_u,
    input  mb_enc_pkg::pix_t                                  dc_v,
    input  mb_enc_pkg::level_t [mb_enc_pkg::Y_SAMPLES-1:0]    y_levels,
    input  mb_enc_pkg::level_t [2*mb_enc_pkg::UV_SAMPLES-1:0] uv_levels,
    input  logic                                              fifo_full,
    output logic                                              fifo_wr,
    output mb_enc_pkg::word_t                                 data_out,
    output logic                                              pack_done
);
    import mb_enc_pkg::*;

    word_t                     hdr_q;
    level_t [Y_SAMPLES-1:0]    y_lv_q;
    level_t [2*UV_SAMPLES-1:0] uv_lv_q;
    logic                      busy;
    logic [2:0]                word_cnt;

    always_ff @(posedge clk) begin
        if (y_valid) begin
            hdr_q   <= {mb_row, mb_col, dc_y, dc_u, dc_v};
            y_lv_q  <= y_levels;
            uv_lv_q <= uv_levels;
        end
    end

    // Counter only moves on an actual write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            word_cnt <= '0;
        end else if (y_valid) begin
            busy     <= 1'b1;
            word_cnt <= '0;
        end else if (fifo_wr) begin
            if (word_cnt == 3'(WORDS_PER_MB - 1)) begin
                busy     <= 1'b0;
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 3'd1;
            end
        end
    end

    assign fifo_wr   = busy && !fifo_full;
    assign pack_done = fifo_wr && (word_cnt == 3'(WORDS_PER_MB - 1));

    //------------------------------------------------------------------------
    // Word select
    //------------------------------------------------------------------------
    always_comb begin
        case (word_cnt)
            3'd1:    data_out = y_lv_q[3:0];
            3'd2:    data_out = y_lv_q[7:4];
            3'd3:    data_out = y_lv_q[11:8];
            3'd4:    data_out = y_lv_q[15:12];
            3'd5:    data_out = uv_lv_q[UV_SAMPLES-1:0];
            3'd6:    data_out = uv_lv_q[2*UV_SAMPLES-1:UV_SAMPLES];
            default: data_out = hdr_q;
        endcase
    end

    // Both quantize paths are started by the same strobe
    a_valid_align: assert property (
        @(posedge clk) disable iff (!rst_n) y_valid == uv_valid
    );

    a_no_wr_full: assert property (
        @(posedge clk) disable iff (!rst_n) fifo_full |-> !fifo_wr
    );

endmodule

// ==== source/mb_encode_ctrl.sv ====
// Frame scan controller
// Walks the macroblocks in raster order, pulls each one from the source
// FIFO, waits for its words to be packed and steps the context

`timescale 1ns/10ps

module mb_encode_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  mb_enc_pkg::col_t mb_cols_m1,
    input  mb_enc_pkg::row_t mb_rows_m1,
    input  logic             src_empty,
    input  logic             pack_done,
    output logic             mb_start,
    output logic             ctx_update,
    output mb_enc_pkg::col_t mb_col,
    output mb_enc_pkg::row_t mb_row,
    output logic             done
);
    import mb_enc_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        last_col;
    logic        last_mb;

    assign last_col = (mb_col == mb_cols_m1);
    assign last_mb  = last_col && (mb_row == mb_rows_m1);

    //------------------------------------------------------------------------
    // State machine
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = INIT;
                end
            end
            INIT: begin
                state_nxt = FETCH;
            end
            FETCH: begin
                if (!src_empty) begin
                    state_nxt = WAIT_PACK;
                end
            end
            WAIT_PACK: begin
                if (pack_done) begin
                    state_nxt = ADVANCE;
                end
            end
            ADVANCE: begin
                state_nxt = last_mb ? DONE : FETCH;
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // Raster position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mb_col <= '0;
            mb_row <= '0;
        end else if (state == INIT) begin
            mb_col <= '0;
            mb_row <= '0;
        end else if (state == ADVANCE && !last_mb) begin
            mb_col <= last_col ? '0 : mb_col + 4'd1;
            mb_row <= last_col ? mb_row + 8'd1 : mb_row;
        end
    end

    // Source read is the start strobe for both quantize paths
    assign mb_start   = (state == FETCH) && !src_empty;
    assign ctx_update = (state == ADVANCE);
    assign done       = (state == DONE);

    a_no_rd_empty: assert property (
        @(posedge clk) disable iff (!rst_n) mb_start |-> !src_empty
    );

endmodule

// ==== source/mb_encode_top.sv ====
// Intra macroblock encoder core, top level
// Controller, context store, luma and chroma quantize paths and packer

`timescale 1ns/10ps

module mb_encode_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  mb_enc_pkg::col_t      mb_cols_m1,
    input  mb_enc_pkg::row_t      mb_rows_m1,
    input  mb_enc_pkg::qshift_t   q_shift_y,
    input  mb_enc_pkg::qshift_t   q_shift_uv,
    input  logic [127:0]          y_in,
    input  logic [63:0]           uv_in,
    input  logic                  src_empty,
    input  logic                  fifo_full,
    output logic                  src_rd,
    output logic                  fifo_wr,
    output mb_enc_pkg::word_t     data_out,
    output logic                  done
);
    import mb_enc_pkg::*;

    logic                      mb_start;
    logic                      ctx_update;
    logic                      pack_done;
    logic                      y_valid;
    logic                      uv_valid;
    col_t                      mb_col;
    row_t                      mb_row;
    pix_t [3:0]                top_y;
    pix_t [3:0]                left_y;
    pix_t [3:0]                top_uv;
    pix_t [3:0]                left_uv;
    pix_t                      dc_y;
    pix_t                      dc_u;
    pix_t                      dc_v;
    level_t [Y_SAMPLES-1:0]    y_levels;
    level_t [2*UV_SAMPLES-1:0] uv_levels;
    pix_t [Y_SAMPLES-1:0]      y_recon;
    pix_t [2*UV_SAMPLES-1:0]   uv_recon;

    assign src_rd = mb_start;

    mb_encode_ctrl ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .mb_cols_m1 (mb_cols_m1),
        .mb_rows_m1 (mb_rows_m1),
        .src_empty  (src_empty),
        .pack_done  (pack_done),
        .mb_start   (mb_start),
        .ctx_update (ctx_update),
        .mb_col     (mb_col),
        .mb_row     (mb_row),
        .done       (done)
    );

    mb_context_store ctx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mb_col     (mb_col),
        .mb_row     (mb_row),
        .ctx_update (ctx_update),
        .y_recon    (y_recon),
        .uv_recon   (uv_recon),
        .top_y      (top_y),
        .left_y     (left_y),
        .top_uv     (top_uv),
        .left_uv    (left_uv)
    );

    luma_dc_quant luma_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mb_start  (mb_start),
        .y_in      (y_in),
        .top_y     (top_y),
        .left_y    (left_y),
        .q_shift_y (q_shift_y),
        .y_valid   (y_valid),
        .dc_y      (dc_y),
        .y_levels  (y_levels),
        .y_recon   (y_recon)
    );

    chroma_dc_quant chroma_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mb_start   (mb_start),
        .uv_in      (uv_in),
        .top_uv     (top_uv),
        .left_uv    (left_uv),
        .q_shift_uv (q_shift_uv),
        .uv_valid   (uv_valid),
        .dc_u       (dc_u),
        .dc_v       (dc_v),
        .uv_levels  (uv_levels),
        .uv_recon   (uv_recon)
    );

    mb_level_packer packer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .y_valid   (y_valid),
        .uv_valid  (uv_valid),
        .mb_col    (mb_col),
        .mb_row    (mb_row),
        .dc_y      (dc_y),
        .dc_u      (dc_u),
        .dc_v      (dc_v),
        .y_levels  (y_levels),
        .uv_levels (uv_levels),
        .fifo_full (fifo_full),
        .fifo_wr   (fifo_wr),
        .data_out  (data_out),
        .pack_done (pack_done)
    );

endmodule

// ==== tb/mb_encode_model.svh ====
// Reference model, value check and directed tests for the encoder testbench
// Expected words follow the DC prediction and shift quantizer rules

`ifndef MB_ENCODE_MODEL_SVH
`define MB_ENCODE_MODEL_SVH

    // Reconstructed context with U in entries 0..1 and V in 2..3
    int ctx_top_y   [MAX_MB_COLS][4];
    int ctx_top_uv  [MAX_MB_COLS][4];
    int ctx_left_y  [4];
    int ctx_left_uv [4];

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $finish;
    endtask

    function automatic int exp_level(input int s, input int dc, input int q);
        int diff;
        int mag;
        diff = s - dc;
        mag  = (diff < 0 ? -diff : diff) >> q;
        return (diff < 0) ? -mag : mag;
    endfunction

    function automatic int exp_recon(input int dc, input int lv, input int q);
        int val;
        val = (lv < 0) ? dc - ((-lv) << q) : dc + (lv << q);
        return (val < 0) ? 0 : ((val > 255) ? 255 : val);
    endfunction

    // Index 0..15 luma, 16..19 U, 20..23 V
    task automatic model_mb(input logic [127:0] y, input logic [63:0] uv,
                            input int col, input int row);
        int    t_y[4];
        int    l_y[4];
        int    t_uv[4];
        int    l_uv[4];
        int    dc[3];
        int    lv[24];
        int    rec[24];
        int    sel;
        int    smp;
        word_t w;
        for (int i = 0; i < 4; i++) begin
            t_y[i]  = (row == 0) ? TOP_DEFAULT : ctx_top_y[col][i];
            t_uv[i] = (row == 0) ? TOP_DEFAULT : ctx_top_uv[col][i];
            l_y[i]  = (col == 0) ? LEFT_DEFAULT : ctx_left_y[i];
            l_uv[i] = (col == 0) ? LEFT_DEFAULT : ctx_left_uv[i];
        end
        dc[0] = (4 + t_y[0] + t_y[1] + t_y[2] + t_y[3]
                 + l_y[0] + l_y[1] + l_y[2] + l_y[3]) >> 3;
        dc[1] = (2 + t_uv[0] + t_uv[1] + l_uv[0] + l_uv[1]) >> 2;
        dc[2] = (2 + t_uv[2] + t_uv[3] + l_uv[2] + l_uv[3]) >> 2;
        for (int i = 0; i < 24; i++) begin
            sel    = (i < 16) ? 0 : ((i < 20) ? 1 : 2);
            smp    = (i < 16) ? y[8*i +: 8] : uv[8*(i-16) +: 8];
            lv[i]  = exp_level(smp, dc[sel], (i < 16) ? q_shift_y : q_shift_uv);
            rec[i] = exp_recon(dc[sel], lv[i], (i < 16) ? q_shift_y : q_shift_uv);
        end
        exp_q.push_back({8'(row), 4'(col), 8'(dc[0]), 8'(dc[1]), 8'(dc[2])});
        for (int k = 0; k < 6; k++) begin
            w = '0;
            for (int j = 0; j < 4; j++) begin
                w[9*j +: 9] = 9'(lv[4*k+j]);
            end
            exp_q.push_back(w);
        end
        for (int i = 0; i < 4; i++) begin
            ctx_top_y[col][i] = rec[12+i];
            ctx_left_y[i]     = rec[4*i+3];
        end
        ctx_top_uv[col] = '{rec[18], rec[19], rec[22], rec[23]};
        ctx_left_uv     = '{rec[17], rec[19], rec[21], rec[23]};
    endtask

    function automatic logic [127:0] rand_block();
        logic [127:0] v;
        for (int i = 0; i < 4; i++) begin
            v[32*i +: 32] = $urandom;
        end
        return v;
    endfunction

    //------------------------------------------------------------------------
    // Frame helpers
    //------------------------------------------------------------------------
    task automatic queue_mb(input logic [127:0] y, input logic [63:0] uv,
                            input int col, input int row);
        src_y_q.push_back(y);
        src_uv_q.push_back(uv);
        model_mb(y, uv, col, row);
    endtask

    task automatic begin_frame(input int cm1, input int rm1, input int qy, input int quv);
        @(negedge clk);
        mb_cols_m1 = col_t'(cm1);
        mb_rows_m1 = row_t'(rm1);
        q_shift_y  = qshift_t'(qy);
        q_shift_uv = qshift_t'(quv);
        got_q.delete();
        exp_q.delete();
        done_cnt      = 0;
        words_at_done = 0;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_words(input int n);
        int cycles;
        cycles = 0;
        while (got_q.size() < n && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (got_q.size() < n) begin
            abort_run($sformatf("Timeout: %0d of %0d output words arrived", got_q.size(), n));
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done_cnt == 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (done_cnt == 0) begin
            abort_run("Timeout: the frame never signalled done");
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic check_frame_end(input int n_words);
        check_val("word_count", got_q.size(), exp_q.size());
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_val($sformatf("data_out[%0d]", i), got_q[i], exp_q[i]);
        end
        check_val("done_count", done_cnt, 1);
        check_val("words_at_done", words_at_done, n_words);
    endtask

    task automatic encode_random_frame(input int cm1, input int rm1, input int qy,
                                       input int quv);
        begin_frame(cm1, rm1, qy, quv);
        for (int r = 0; r <= rm1; r++) begin
            for (int c = 0; c <= cm1; c++) begin
                queue_mb(rand_block(), 64'(rand_block()), c, r);
            end
        end
        pulse_start();
        wait_done();
        check_frame_end((cm1 + 1) * (rm1 + 1) * WORDS_PER_MB);
    endtask

    task automatic report_test(input int num, input string name, input int err0);
        if (err_cnt == err0) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            fail_tests++;
            $display("Test %0d %s: %0d errors", num, name, err_cnt - err0);
        end
    endtask

    //------------------------------------------------------------------------
    // Directed tests
    //------------------------------------------------------------------------
    task automatic test_edge_defaults();
        int           err0;
        logic [127:0] y;
        logic [63:0]  uv;
        err0 = err_cnt;
        for (int i = 0; i < 16; i++) begin
            y[8*i +: 8] = 8'(112 + 2 * i);
        end
        for (int i = 0; i < 8; i++) begin
            uv[8*i +: 8] = 8'(125 + i);
        end
        begin_frame(0, 0, 0, 0);
        queue_mb(y, uv, 0, 0);
        pulse_start();
        wait_done();
        if (got_q.size() > 0) begin
            check_val("header", got_q[0], {8'd0, 4'd0, 8'd128, 8'd128, 8'd128});
        end
        check_frame_end(WORDS_PER_MB);
        report_test(1, "edge defaults", err0);
    endtask

    task automatic test_shift_quant();
        int err0;
        err0 = err_cnt;
        encode_random_frame(0, 0, 2, 1);
        report_test(2, "shift quantizer", err0);
    endtask

    task automatic test_context_frame();
        int err0;
        err0 = err_cnt;
        encode_random_frame(2, 1, 1, 2);
        report_test(3, "context propagation", err0);
    endtask

    task automatic test_back_pressure();
        int err0;
        err0      = err_cnt;
        full_rand = 1'b1;
        encode_random_frame(1, 1, 3, 0);
        full_rand = 1'b0;
        report_test(4, "output back-pressure", err0);
    endtask

    task automatic test_source_gap();
        int err0;
        err0 = err_cnt;
        begin_frame(0, 1, 1, 1);
        queue_mb(rand_block(), 64'(rand_block()), 0, 0);
        pulse_start();
        wait_words(WORDS_PER_MB);
        // Source stays empty so nothing may move
        repeat (20) begin
            @(negedge clk);
            check_val("src_rd", src_rd, 0);
            check_val("fifo_wr", fifo_wr, 0);
            check_val("done", done, 0);
        end
        queue_mb(rand_block(), 64'(rand_block()), 0, 1);
        wait_done();
        check_frame_end(2 * WORDS_PER_MB);
        report_test(5, "source gap", err0);
    endtask

`endif

// ==== tb/tb_mb_encode.sv ====
// Testbench for the intra macroblock encoder core
// Show-ahead source FIFO model, output word capture and test sequence

`timescale 1ns/10ps

module tb_mb_encode;
    import mb_enc_pkg::*;

    localparam int SEED       = 73;
    localparam int WAIT_LIMIT = 2000;

    logic         clk;
    logic         rst_n;
    logic         start;
    col_t         mb_cols_m1;
    row_t         mb_rows_m1;
    qshift_t      q_shift_y;
    qshift_t      q_shift_uv;
    logic [127:0] y_in;
    logic [63:0]  uv_in;
    logic         src_empty;
    logic         fifo_full;
    logic         src_rd;
    logic         fifo_wr;
    word_t        data_out;
    logic         done;

    logic [127:0] src_y_q[$];
    logic [63:0]  src_uv_q[$];
    word_t        got_q[$];
    word_t        exp_q[$];
    logic         full_rand;
    int           done_cnt;
    int           words_at_done;
    int           err_cnt;
    int           fail_tests;

    `include "mb_encode_model.svh"

    mb_encode_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .mb_cols_m1 (mb_cols_m1),
        .mb_rows_m1 (mb_rows_m1),
        .q_shift_y  (q_shift_y),
        .q_shift_uv (q_shift_uv),
        .y_in       (y_in),
        .uv_in      (uv_in),
        .src_empty  (src_empty),
        .fifo_full  (fifo_full),
        .src_rd     (src_rd),
        .fifo_wr    (fifo_wr),
        .data_out   (data_out),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Source FIFO head and back-pressure change on the falling edge
    always @(negedge clk) begin
        src_empty = (src_y_q.size() == 0);
        if (src_y_q.size() != 0) begin
            y_in  = src_y_q[0];
            uv_in = src_uv_q[0];
        end
        fifo_full = full_rand ? ($urandom % 3 == 0) : 1'b0;
    end

    //------------------------------------------------------------------------
    // Monitor
    //------------------------------------------------------------------------
    always @(posedge clk) begin
        if (src_rd && src_y_q.size() != 0) begin
            void'(src_y_q.pop_front());
            void'(src_uv_q.pop_front());
        end
        if (fifo_full) begin
            check_val("fifo_wr", fifo_wr, 0);
        end
        if (fifo_wr) begin
            got_q.push_back(data_out);
        end
        if (done) begin
            done_cnt++;
            words_at_done = got_q.size();
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_n         = 1'b0;
        start         = 1'b0;
        mb_cols_m1    = '0;
        mb_rows_m1    = '0;
        q_shift_y     = '0;
        q_shift_uv    = '0;
        y_in          = '0;
        uv_in         = '0;
        src_empty     = 1'b1;
        fifo_full     = 1'b0;
        full_rand     = 1'b0;
        done_cnt      = 0;
        words_at_done = 0;
        err_cnt       = 0;
        fail_tests    = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_val("src_rd", src_rd, 0);
        check_val("fifo_wr", fifo_wr, 0);
        check_val("done", done, 0);

        test_edge_defaults();
        test_shift_quant();
        test_context_frame();
        test_back_pressure();
        test_source_gap();

        $display("Tests run: 5, tests failed: %0d, check errors: %0d", fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+tb
source/mb_enc_pkg.sv
source/mb_context_store.sv
source/luma_dc_quant.sv
source/chroma_dc_quant.sv
source/mb_level_packer.sv
source/mb_encode_ctrl.sv
source/mb_encode_top.sv
tb/tb_mb_encode.sv
